// File: hdl/jpeg_quant_consts.svh
// Widths and depths of the JPEG quantizer stage, included by the RTL and the testbench
`ifndef JPEG_QUANT_CONSTS_SVH
`define JPEG_QUANT_CONSTS_SVH

// Coefficient in, quantized value out
`define JQ_DW           15
`define JQ_QW           11
// Reciprocal factor, scaled by 2^(JQ_MBITS-1)
`define JQ_MBITS        13
`define JQ_MULT_STAGES  4

`define JQ_BLOCK_SIZE   64
`define JQ_PAIRS        32
`define JQ_MCU_BLOCKS   6

`endif

// File: hdl/jpeg_quant_pkg.sv
// Types and the zig-zag lookup for the JPEG quantizer, referenced by scoped name
`include "jpeg_quant_consts.svh"

package jpeg_quant_pkg;

    typedef logic signed [`JQ_DW-1:0]    coef_t;
    typedef logic        [`JQ_MBITS-1:0] qfac_t;
    typedef logic signed [`JQ_QW-1:0]    qout_t;

    // Block buffer either takes rows or hands out zig-zag pairs
    typedef enum logic {
        ZZ_FILL,
        ZZ_DRAIN
    } zz_state_t;

    // Natural row-major index for each zig-zag position
    localparam logic [5:0] ZZ_NAT [`JQ_BLOCK_SIZE] = '{
         0,  1,  8, 16,  9,  2,  3, 10,
        17, 24, 32, 25, 18, 11,  4,  5,
        12, 19, 26, 33, 40, 48, 41, 34,
        27, 20, 13,  6,  7, 14, 21, 28,
        35, 42, 49, 56, 57, 50, 43, 36,
        29, 22, 15, 23, 30, 37, 44, 51,
        58, 59, 52, 45, 38, 31, 39, 46,
        53, 60, 61, 54, 47, 55, 62, 63
    };

    function automatic logic [5:0] de_zigzag(input logic [5:0] pos);
        return ZZ_NAT[pos];
    endfunction

endpackage

// File: hdl/zigzag_buffer.sv
// One-block coefficient store, written by rows and read back as zig-zag pairs, with MCU count
`include "jpeg_quant_consts.svh"

module zigzag_buffer (
    input  logic                  clk,
    input  logic                  resetn,
    input  jpeg_quant_pkg::coef_t di [7:0],
    input  logic                  di_valid,
    input  logic [2:0]            di_cnt,
    input  logic                  q_hold,
    output logic                  di_hold,
    output logic                  rd_en,
    output jpeg_quant_pkg::coef_t rd_data [1:0],
    output logic [4:0]            rd_pair,
    output logic                  chroma
);

    jpeg_quant_pkg::zz_state_t state;
    jpeg_quant_pkg::coef_t     mem [`JQ_BLOCK_SIZE];
    logic [2:0]                mcu_cnt;
    logic                      row_wr;
    logic                      last_pair;

    assign di_hold   = (state == jpeg_quant_pkg::ZZ_DRAIN);
    assign row_wr    = di_valid && (state == jpeg_quant_pkg::ZZ_FILL);
    assign rd_en     = di_hold && !q_hold;
    assign last_pair = (rd_pair == 5'(`JQ_PAIRS - 1));
    // Four luma blocks first, then Cb and Cr
    assign chroma    = (mcu_cnt >= 3'(`JQ_MCU_BLOCKS - 2));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= jpeg_quant_pkg::ZZ_FILL;
            rd_pair <= '0;
            mcu_cnt <= '0;
        end else if (state == jpeg_quant_pkg::ZZ_FILL) begin
            if (row_wr && di_cnt == 3'd7) begin
                state <= jpeg_quant_pkg::ZZ_DRAIN;
            end
        end else if (rd_en) begin
            rd_pair <= rd_pair + 5'd1;
            if (last_pair) begin
                state   <= jpeg_quant_pkg::ZZ_FILL;
                mcu_cnt <= (mcu_cnt == 3'(`JQ_MCU_BLOCKS - 1)) ? 3'd0 : mcu_cnt + 3'd1;
            end
        end
    end

    // Rows land at natural addresses
    always_ff @(posedge clk) begin
        if (row_wr) begin
            for (int j = 0; j < 8; j++) begin
                mem[{di_cnt, 3'(j)}] <= di[j];
            end
        end
    end

    // Zig-zag positions 2*rd_pair and 2*rd_pair+1
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            rd_data[j] = mem[jpeg_quant_pkg::de_zigzag({rd_pair, 1'(j)})];
        end
    end

endmodule

// File: hdl/quant_tables.sv
// Luma and chroma reciprocal quantizer tables, loaded by a write port, read two factors per pair
`include "jpeg_quant_consts.svh"

module quant_tables (
    input  logic                  clk,
    input  logic                  tbl_we,
    input  logic [6:0]            tbl_addr,
    input  jpeg_quant_pkg::qfac_t tbl_data,
    input  logic                  re,
    input  logic                  chroma,
    input  logic [4:0]            pair,
    output jpeg_quant_pkg::qfac_t rd [1:0]
);

    // Luma in words 0..63, chroma in 64..127, both in natural order
    jpeg_quant_pkg::qfac_t tbl [2*`JQ_BLOCK_SIZE];
    logic [6:0]            ra [1:0];

    // Same zig-zag mapping as the block buffer, so factors follow the read order
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            ra[j] = {chroma, jpeg_quant_pkg::de_zigzag({pair, 1'(j)})};
        end
    end

    always_ff @(posedge clk) begin
        if (tbl_we) begin
            tbl[tbl_addr] <= tbl_data;
        end
    end

    always_ff @(posedge clk) begin
        if (re) begin
            for (int j = 0; j < 2; j++) begin
                rd[j] <= tbl[ra[j]];
            end
        end
    end

endmodule

// File: hdl/quant_mult.sv
// Four-stage signed coefficient by unsigned factor multiplier with stall, one per output lane
`include "jpeg_quant_consts.svh"

module quant_mult (
    input  logic                               clk,
    input  logic                               resetn,
    input  logic                               en,
    input  logic                               in_valid,
    input  jpeg_quant_pkg::coef_t              a_in,
    input  jpeg_quant_pkg::qfac_t              b_in,
    output logic signed [`JQ_DW+`JQ_MBITS-1:0] out,
    output logic                               out_valid
);

    // Factor split into a 7-bit low part and the remaining high part
    localparam int LO_BITS = 7;
    localparam int HI_BITS = `JQ_MBITS - LO_BITS;
    localparam int PW      = `JQ_DW + `JQ_MBITS;

    jpeg_quant_pkg::coef_t            a_r;
    jpeg_quant_pkg::qfac_t            b_r;
    logic signed [`JQ_DW+LO_BITS-1:0] pp_lo;
    logic signed [`JQ_DW+HI_BITS-1:0] pp_hi;
    logic signed [PW-1:0]             sum_r;
    logic [`JQ_MULT_STAGES-1:0]       vld;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            vld <= '0;
        end else if (en) begin
            vld <= {vld[`JQ_MULT_STAGES-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            a_r   <= a_in;
            b_r   <= b_in;
            // Zero-extended factor halves keep the products signed
            pp_lo <= a_r * $signed({1'b0, b_r[LO_BITS-1:0]});
            pp_hi <= a_r * $signed({1'b0, b_r[`JQ_MBITS-1:LO_BITS]});
            sum_r <= (PW'(pp_hi) <<< LO_BITS) + PW'(pp_lo);
            out   <= sum_r;
        end
    end

    assign out_valid = vld[`JQ_MULT_STAGES-1];

endmodule

// File: hdl/quant.sv
// JPEG quantizer top, takes DCT rows and emits zig-zag quantized pairs with pair index and chroma tag
`include "jpeg_quant_consts.svh"

module quant (
    input  logic                  clk,
    input  logic                  resetn,
    input  jpeg_quant_pkg::coef_t di [7:0],
    input  logic                  di_valid,
    input  logic [2:0]            di_cnt,
    output logic                  di_hold,
    input  logic                  q_hold,
    input  logic                  tbl_we,
    input  logic [6:0]            tbl_addr,
    input  jpeg_quant_pkg::qfac_t tbl_data,
    output jpeg_quant_pkg::qout_t q [1:0],
    output logic                  q_valid,
    output logic [4:0]            q_cnt,
    output logic                  q_chroma
);

    logic                               rd_en;
    jpeg_quant_pkg::coef_t              rd_data [1:0];
    logic [4:0]                         rd_pair;
    logic                               chroma;
    jpeg_quant_pkg::qfac_t              factor [1:0];
    jpeg_quant_pkg::coef_t              di0 [1:0];
    logic                               di0_valid;
    logic [5:0]                         tag0;
    logic [5:0]                         tag_dly [`JQ_MULT_STAGES];
    logic                               mult_en;
    logic signed [`JQ_DW+`JQ_MBITS-1:0] mult_out [1:0];

    // Whole drain path freezes while the sink holds
    assign mult_en = !q_hold;

    zigzag_buffer u_buffer (
        .clk     (clk),
        .resetn  (resetn),
        .di      (di),
        .di_valid(di_valid),
        .di_cnt  (di_cnt),
        .q_hold  (q_hold),
        .di_hold (di_hold),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .rd_pair (rd_pair),
        .chroma  (chroma)
    );

    quant_tables u_tables (
        .clk     (clk),
        .tbl_we  (tbl_we),
        .tbl_addr(tbl_addr),
        .tbl_data(tbl_data),
        .re      (rd_en),
        .chroma  (chroma),
        .pair    (rd_pair),
        .rd      (factor)
    );

    // Coefficients and tag are captured in step with the factor read
    always_ff @(posedge clk) begin
        if (!resetn) begin
            di0_valid <= 1'b0;
        end else if (mult_en) begin
            di0_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            di0  <= rd_data;
            tag0 <= {chroma, rd_pair};
        end
    end

    // Tag follows the products through the multiplier depth
    always_ff @(posedge clk) begin
        if (mult_en) begin
            tag_dly[0] <= tag0;
            for (int i = 1; i < `JQ_MULT_STAGES; i++) begin
                tag_dly[i] <= tag_dly[i-1];
            end
        end
    end

    quant_mult u_mult0 (
        .clk      (clk),
        .resetn   (resetn),
        .en       (mult_en),
        .in_valid (di0_valid),
        .a_in     (di0[0]),
        .b_in     (factor[0]),
        .out      (mult_out[0]),
        .out_valid(q_valid)
    );

    quant_mult u_mult1 (
        .clk      (clk),
        .resetn   (resetn),
        .en       (mult_en),
        .in_valid (di0_valid),
        .a_in     (di0[1]),
        .b_in     (factor[1]),
        .out      (mult_out[1]),
        .out_valid()
    );

    // Arithmetic shift floors toward minus infinity, then keep the low JQ_QW bits
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            q[j] = jpeg_quant_pkg::qout_t'(mult_out[j] >>> (`JQ_MBITS - 1));
        end
    end

    assign {q_chroma, q_cnt} = tag_dly[`JQ_MULT_STAGES-1];

endmodule

// File: bench/quant_props.sv
// Concurrent checks on the quantizer ports, bound into every quant instance
`include "jpeg_quant_consts.svh"

module quant_props (
    input logic                     clk,
    input logic                     resetn,
    input logic                     di_valid,
    input logic [2:0]               di_cnt,
    input logic                     di_hold,
    input logic                     q_hold,
    input logic                     q_valid,
    input logic [4:0]               q_cnt,
    input logic signed [`JQ_QW-1:0] q0,
    input logic signed [`JQ_QW-1:0] q1
);

    jpeg_quant_pkg::zz_state_t buf_state;
    logic [4:0]                next_cnt;
    logic                      seen_pair;
    logic                      consume;
    // Number of failed assertions so far
    int                        fail_cnt = 0;

    assign buf_state = di_hold ? jpeg_quant_pkg::ZZ_DRAIN : jpeg_quant_pkg::ZZ_FILL;
    assign consume   = q_valid && !q_hold;

    // Index expected on the next consumed pair
    always_ff @(posedge clk) begin
        if (!resetn) begin
            seen_pair <= 1'b0;
            next_cnt  <= '0;
        end else if (consume) begin
            seen_pair <= 1'b1;
            next_cnt  <= q_cnt + 5'd1;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!resetn)
        q_hold |=> $stable(q_valid) && $stable(q0) && $stable(q1))
        else begin
            fail_cnt++;
            $error("Output changed while q_hold was high");
        end

    a_row7_hold: assert property (@(posedge clk) disable iff (!resetn)
        di_valid && buf_state == jpeg_quant_pkg::ZZ_FILL && di_cnt == 3'd7 |=> di_hold)
        else begin
            fail_cnt++;
            $error("di_hold did not rise after row 7");
        end

    a_cnt_step: assert property (@(posedge clk) disable iff (!resetn)
        consume && seen_pair |-> q_cnt == next_cnt)
        else begin
            fail_cnt++;
            $error("q_cnt did not step by one between pairs");
        end

    a_reset_quiet: assert property (@(posedge clk)
        !resetn && $past(!resetn) |-> !q_valid)
        else begin
            fail_cnt++;
            $error("q_valid high during reset");
        end

endmodule

bind quant quant_props u_props (
    .clk     (clk),
    .resetn  (resetn),
    .di_valid(di_valid),
    .di_cnt  (di_cnt),
    .di_hold (di_hold),
    .q_hold  (q_hold),
    .q_valid (q_valid),
    .q_cnt   (q_cnt),
    .q0      (q[0]),
    .q1      (q[1])
);

// File: bench/quant_tb.sv
// Testbench for the quantizer, loads tables and blocks from the tests file and checks every pair
`include "jpeg_quant_consts.svh"

module quant_tb;

    localparam int TBL_WORDS  = 2 * `JQ_BLOCK_SIZE;
    localparam int BLK_WORDS  = 2 * `JQ_BLOCK_SIZE;
    localparam int VEC_WORDS  = TBL_WORDS + `JQ_MCU_BLOCKS * BLK_WORDS;
    localparam int NUM_PAIRS  = `JQ_MCU_BLOCKS * `JQ_PAIRS;
    localparam int TIMEOUT_CYCLES = `JQ_MCU_BLOCKS * `JQ_BLOCK_SIZE * 4 + TBL_WORDS + 200;

    logic                  clk;
    logic                  resetn;
    jpeg_quant_pkg::coef_t di [7:0];
    logic                  di_valid;
    logic [2:0]            di_cnt;
    logic                  di_hold;
    logic                  q_hold;
    logic                  tbl_we;
    logic [6:0]            tbl_addr;
    jpeg_quant_pkg::qfac_t tbl_data;
    jpeg_quant_pkg::qout_t q [1:0];
    logic                  q_valid;
    logic [4:0]            q_cnt;
    logic                  q_chroma;

    logic [15:0] vec [VEC_WORDS];
    int          errors;
    int          consumed;

    quant DUT (
        .clk     (clk),
        .resetn  (resetn),
        .di      (di),
        .di_valid(di_valid),
        .di_cnt  (di_cnt),
        .di_hold (di_hold),
        .q_hold  (q_hold),
        .tbl_we  (tbl_we),
        .tbl_addr(tbl_addr),
        .tbl_data(tbl_data),
        .q       (q),
        .q_valid (q_valid),
        .q_cnt   (q_cnt),
        .q_chroma(q_chroma)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic load_tables();
        for (int i = 0; i < TBL_WORDS; i++) begin
            @(negedge clk);
            tbl_we   = 1'b1;
            tbl_addr = 7'(i);
            tbl_data = vec[i][`JQ_MBITS-1:0];
        end
        @(negedge clk);
        tbl_we = 1'b0;
    endtask

    // A row offered while di_hold is high is simply offered again
    task automatic send_blocks();
        int r;
        int base;
        for (int b = 0; b < `JQ_MCU_BLOCKS; b++) begin
            base = TBL_WORDS + b * BLK_WORDS;
            r = 0;
            while (r < 8) begin
                @(negedge clk);
                di_valid = 1'b1;
                di_cnt   = 3'(r);
                for (int j = 0; j < 8; j++) begin
                    di[j] = vec[base + r * 8 + j][`JQ_DW-1:0];
                end
                if (!di_hold) begin
                    r++;
                end
            end
        end
        @(negedge clk);
        di_valid = 1'b0;
    endtask

    task automatic check_pair(input int idx);
        int blk;
        int k;
        logic [`JQ_QW-1:0] exp_q;
        blk = idx / `JQ_PAIRS;
        k   = idx % `JQ_PAIRS;
        if (q_cnt !== 5'(k)) begin
            $display("Mismatch at %0t: block %0d pair %0d has q_cnt %0d", $time, blk, k, q_cnt);
            errors++;
        end
        if (q_chroma !== (blk >= 4)) begin
            $display("Mismatch at %0t: block %0d pair %0d has q_chroma %0b",
                     $time, blk, k, q_chroma);
            errors++;
        end
        for (int j = 0; j < 2; j++) begin
            exp_q = vec[TBL_WORDS + blk * BLK_WORDS + `JQ_BLOCK_SIZE + 2 * k + j][`JQ_QW-1:0];
            if (q[j] !== exp_q) begin
                $display("Mismatch at %0t: block %0d pair %0d q[%0d] = %0d, expected %0d",
                         $time, blk, k, j, q[j], $signed(exp_q));
                errors++;
            end
        end
    endtask

    // Random stalls, one pair checked on each edge that consumes it
    task automatic receive_pairs();
        while (consumed < NUM_PAIRS) begin
            @(negedge clk);
            q_hold = ($urandom % 4) == 0;
            if (q_valid && !q_hold) begin
                check_pair(consumed);
                consumed++;
            end
        end
        // q_hold is already low here, since the last pair was just consumed
        repeat (12) begin
            @(negedge clk);
            if (q_valid) begin
                $display("Extra output pair after the last block at %0t", $time);
                errors++;
            end
        end
    endtask

    initial begin
        resetn   = 1'b0;
        di_valid = 1'b0;
        di_cnt   = '0;
        q_hold   = 1'b0;
        tbl_we   = 1'b0;
        tbl_addr = '0;
        tbl_data = '0;
        for (int j = 0; j < 8; j++) begin
            di[j] = '0;
        end
        errors   = 0;
        consumed = 0;
        void'($urandom(27374));
        $readmemh("bench/quant_tests.txt", vec);

        repeat (16) @(negedge clk);
        resetn = 1'b1;
        load_tables();

        fork
            send_blocks();
            receive_pairs();
        join

        $display("Checked %0d pairs, %0d errors, %0d assertion failures",
                 consumed, errors, DUT.u_props.fail_cnt);
        if (errors == 0 && DUT.u_props.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout, only %0d of %0d output pairs arrived", consumed, NUM_PAIRS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: bench/quant_tests.txt
// Words 0..127: reciprocal factors, luma then chroma, natural order
// Then per block: 8 input rows (natural order) and 64 expected quantized values (zig-zag order)
0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800
0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800
0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800
0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800 0800
0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400
0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400
0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400
0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0400
// Block 0, luma, coefficient n-32
FFE0 FFE1 FFE2 FFE3 FFE4 FFE5 FFE6 FFE7
FFE8 FFE9 FFEA FFEB FFEC FFED FFEE FFEF
FFF0 FFF1 FFF2 FFF3 FFF4 FFF5 FFF6 FFF7
FFF8 FFF9 FFFA FFFB FFFC FFFD FFFE FFFF
0000 0001 0002 0003 0004 0005 0006 0007
0008 0009 000A 000B 000C 000D 000E 000F
0010 0011 0012 0013 0014 0015 0016 0017
0018 0019 001A 001B 001C 001D 001E 001F
FFF0 FFF0 FFF4 FFF8 FFF4 FFF1 FFF1 FFF5 FFF8 FFFC 0000 FFFC FFF9 FFF5 FFF2 FFF2
FFF6 FFF9 FFFD 0000 0004 0008 0004 0001 FFFD FFFA FFF6 FFF3 FFF3 FFF7 FFFA FFFE
0001 0005 0008 000C 000C 0009 0005 0002 FFFE FFFB FFF7 FFFB FFFF 0002 0006 0009
000D 000D 000A 0006 0003 FFFF 0003 0007 000A 000E 000E 000B 0007 000B 000F 000F
// Block 1, luma, coefficient n-25
FFE7 FFE8 FFE9 FFEA FFEB FFEC FFED FFEE
FFEF FFF0 FFF1 FFF2 FFF3 FFF4 FFF5 FFF6
FFF7 FFF8 FFF9 FFFA FFFB FFFC FFFD FFFE
FFFF 0000 0001 0002 0003 0004 0005 0006
0007 0008 0009 000A 000B 000C 000D 000E
000F 0010 0011 0012 0013 0014 0015 0016
0017 0018 0019 001A 001B 001C 001D 001E
001F 0020 0021 0022 0023 0024 0025 0026
FFF3 FFF4 FFF7 FFFB FFF8 FFF4 FFF5 FFF8 FFFC FFFF 0003 0000 FFFC FFF9 FFF5 FFF6
FFF9 FFFD 0000 0004 0007 000B 0008 0004 0001 FFFD FFFA FFF6 FFF7 FFFA FFFE 0001
0005 0008 000C 000F 0010 000C 0009 0005 0002 FFFE FFFB FFFF 0002 0006 0009 000D
0010 0011 000D 000A 0006 0003 0007 000A 000E 0011 0012 000E 000B 000F 0012 0013
// Block 2, luma, coefficient n-45
FFD3 FFD4 FFD5 FFD6 FFD7 FFD8 FFD9 FFDA
FFDB FFDC FFDD FFDE FFDF FFE0 FFE1 FFE2
FFE3 FFE4 FFE5 FFE6 FFE7 FFE8 FFE9 FFEA
FFEB FFEC FFED FFEE FFEF FFF0 FFF1 FFF2
FFF3 FFF4 FFF5 FFF6 FFF7 FFF8 FFF9 FFFA
FFFB FFFC FFFD FFFE FFFF 0000 0001 0002
0003 0004 0005 0006 0007 0008 0009 000A
000B 000C 000D 000E 000F 0010 0011 0012
FFE9 FFEA FFED FFF1 FFEE FFEA FFEB FFEE FFF2 FFF5 FFF9 FFF6 FFF2 FFEF FFEB FFEC
FFEF FFF3 FFF6 FFFA FFFD 0001 FFFE FFFA FFF7 FFF3 FFF0 FFEC FFED FFF0 FFF4 FFF7
FFFB FFFE 0002 0005 0006 0002 FFFF FFFB FFF8 FFF4 FFF1 FFF5 FFF8 FFFC FFFF 0003
0006 0007 0003 0000 FFFC FFF9 FFFD 0000 0004 0007 0008 0004 0001 0005 0008 0009
// Block 3, luma, coefficient n+8
0008 0009 000A 000B 000C 000D 000E 000F
0010 0011 0012 0013 0014 0015 0016 0017
0018 0019 001A 001B 001C 001D 001E 001F
0020 0021 0022 0023 0024 0025 0026 0027
0028 0029 002A 002B 002C 002D 002E 002F
0030 0031 0032 0033 0034 0035 0036 0037
0038 0039 003A 003B 003C 003D 003E 003F
0040 0041 0042 0043 0044 0045 0046 0047
0004 0004 0008 000C 0008 0005 0005 0009 000C 0010 0014 0010 000D 0009 0006 0006
000A 000D 0011 0014 0018 001C 0018 0015 0011 000E 000A 0007 0007 000B 000E 0012
0015 0019 001C 0020 0020 001D 0019 0016 0012 000F 000B 000F 0013 0016 001A 001D
0021 0021 001E 001A 0017 0013 0017 001B 001E 0022 0022 001F 001B 001F 0023 0023
// Block 4, Cb, coefficient n-32
FFE0 FFE1 FFE2 FFE3 FFE4 FFE5 FFE6 FFE7
FFE8 FFE9 FFEA FFEB FFEC FFED FFEE FFEF
FFF0 FFF1 FFF2 FFF3 FFF4 FFF5 FFF6 FFF7
FFF8 FFF9 FFFA FFFB FFFC FFFD FFFE FFFF
0000 0001 0002 0003 0004 0005 0006 0007
0008 0009 000A 000B 000C 000D 000E 000F
0010 0011 0012 0013 0014 0015 0016 0017
0018 0019 001A 001B 001C 001D 001E 001F
FFF8 FFF8 FFFA FFFC FFFA FFF8 FFF8 FFFA FFFC FFFE 0000 FFFE FFFC FFFA FFF9 FFF9
FFFB FFFC FFFE 0000 0002 0004 0002 0000 FFFE FFFD FFFB FFF9 FFF9 FFFB FFFD FFFF
0000 0002 0004 0006 0006 0004 0002 0001 FFFF FFFD FFFB FFFD FFFF 0001 0003 0004
0006 0006 0005 0003 0001 FFFF 0001 0003 0005 0007 0007 0005 0003 0005 0007 0007
// Block 5, Cr, coefficient n-21
FFEB FFEC FFED FFEE FFEF FFF0 FFF1 FFF2
FFF3 FFF4 FFF5 FFF6 FFF7 FFF8 FFF9 FFFA
FFFB FFFC FFFD FFFE FFFF 0000 0001 0002
0003 0004 0005 0006 0007 0008 0009 000A
000B 000C 000D 000E 000F 0010 0011 0012
0013 0014 0015 0016 0017 0018 0019 001A
001B 001C 001D 001E 001F 0020 0021 0022
0023 0024 0025 0026 0027 0028 0029 002A
FFFA FFFB FFFC FFFE FFFD FFFB FFFB FFFD FFFF 0000 0002 0001 FFFF FFFD FFFB FFFC
FFFD FFFF 0001 0003 0004 0006 0005 0003 0001 FFFF FFFE FFFC FFFC FFFE 0000 0001
0003 0005 0007 0008 0009 0007 0005 0003 0002 0000 FFFE 0000 0002 0004 0005 0007
0009 0009 0007 0006 0004 0002 0004 0006 0008 0009 000A 0008 0006 0008 000A 000A

// File: vlog.f
+incdir+hdl
hdl/jpeg_quant_pkg.sv
hdl/zigzag_buffer.sv
hdl/quant_tables.sv
hdl/quant_mult.sv
hdl/quant.sv
bench/quant_props.sv
bench/quant_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= quant_tb
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

$(SIM_BIN): $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
